/* include/noc_macros.svh */
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// Flit payload and buffering
`define NOC_FLIT_WIDTH 32
`define NOC_BUF_DEPTH 4

// Mesh geometry
`define NOC_MESH_DIM 2
`define NOC_NUM_NODES 4

// Every router has one local, one x and one y port
`define NOC_NUM_PORTS 3
`define NOC_PORT_LOCAL 0
`define NOC_PORT_X 1
`define NOC_PORT_Y 2

`endif

/* logic/noc_pkg.sv */
`default_nettype none

`include "noc_macros.svh"

package noc_pkg;

    typedef logic [`NOC_FLIT_WIDTH-1:0] flit_data_t;

    // Low bit is x, high bit is y
    typedef logic [$clog2(`NOC_NUM_NODES)-1:0] node_id_t;

    typedef logic [$clog2(`NOC_NUM_PORTS)-1:0] port_idx_t;

    // Needs to hold 0 up to the full buffer depth
    typedef logic [$clog2(`NOC_BUF_DEPTH+1)-1:0] credit_cnt_t;

    typedef struct packed {
        flit_data_t data;
        node_id_t   dest;
        logic       is_tail;
    } flit_t;

    typedef struct packed {
        flit_t flit;
        logic  send;
    } link_t;

    typedef enum logic {
        ALLOC_IDLE,
        ALLOC_LOCKED
    } alloc_state_t;

endpackage

`default_nettype wire

/* logic/flit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module flit_fifo
    import noc_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  push,
    input  flit_t push_flit,

    input  logic  pop,
    output flit_t head,
    output logic  head_valid,

    output logic  credit
);

    localparam int PTR_W = $clog2(`NOC_BUF_DEPTH);

    flit_t            mem [`NOC_BUF_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    credit_cnt_t      count;

    // Flit storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_flit;
        end
    end

    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + credit_cnt_t'(1);
                2'b01:   count <= count - credit_cnt_t'(1);
                default: count <= count;
            endcase
            // One credit back upstream for every flit that leaves
            credit <= pop;
        end
    end

    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    // Upstream credit counter must keep us from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> (count != credit_cnt_t'(`NOC_BUF_DEPTH)));

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop |-> head_valid);

endmodule

`default_nettype wire

/* logic/credit_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module credit_counter
    import noc_pkg::*;
(
    input  logic clk,
    input  logic rst,

    input  logic sent,
    input  logic credit_return,

    output logic has_credit
);

    credit_cnt_t count;

    // Starts with one credit per slot of the downstream buffer
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= credit_cnt_t'(`NOC_BUF_DEPTH);
        end else begin
            case ({sent, credit_return})
                2'b10:   count <= count - credit_cnt_t'(1);
                2'b01:   count <= count + credit_cnt_t'(1);
                // Send and return together leave the count as is
                default: count <= count;
            endcase
        end
    end

    assign has_credit = (count != '0);

    // A return beyond the buffer depth means a duplicated credit pulse
    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= credit_cnt_t'(`NOC_BUF_DEPTH));

    a_send_with_credit: assert property (@(posedge clk) disable iff (rst)
        sent |-> (count != '0));

endmodule

`default_nettype wire

/* logic/output_allocator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module output_allocator
    import noc_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic [`NOC_NUM_PORTS-1:0] request,
    input  logic [`NOC_NUM_PORTS-1:0] head_is_tail,
    input  logic                      has_credit,

    output logic [`NOC_NUM_PORTS-1:0] grant
);

    localparam int NP = `NOC_NUM_PORTS;

    alloc_state_t state_q;
    port_idx_t    owner_q;
    port_idx_t    pick;
    port_idx_t    sel;
    logic         grant_en;

    // Round-robin search, nearest input after the last winner gets priority.
    // Scanning from the far end lets the closest request overwrite the others
    always_comb begin
        int idx;
        pick = owner_q;
        for (int off = NP; off >= 1; off--) begin
            idx = (int'(owner_q) + off) % NP;
            if (request[idx]) begin
                pick = port_idx_t'(idx);
            end
        end
    end

    // While locked only the packet owner may move
    assign sel      = (state_q == ALLOC_IDLE) ? pick : owner_q;
    assign grant_en = has_credit && request[sel];

    always_comb begin
        grant      = '0;
        grant[sel] = grant_en;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ALLOC_IDLE;
            owner_q <= port_idx_t'(NP - 1);
        end else if (grant_en) begin
            owner_q <= sel;
            // Single flit packets never take the lock
            if (head_is_tail[sel]) begin
                state_q <= ALLOC_IDLE;
            end else begin
                state_q <= ALLOC_LOCKED;
            end
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant));

endmodule

`default_nettype wire

/* logic/noc_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module noc_router
    import noc_pkg::*;
#(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  logic  clk,
    input  logic  rst,

    input  link_t link_in    [`NOC_NUM_PORTS],
    output logic  credit_out [`NOC_NUM_PORTS],

    output link_t link_out   [`NOC_NUM_PORTS],
    input  logic  credit_in  [`NOC_NUM_PORTS]
);

    localparam int NP = `NOC_NUM_PORTS;

    // Per input
    flit_t          head       [NP];
    logic [NP-1:0]  head_valid;
    logic [NP-1:0]  head_tail;
    port_idx_t      route      [NP];
    logic [NP-1:0]  pop;

    // Per output
    logic [NP-1:0]  req        [NP];
    logic [NP-1:0]  grant      [NP];
    logic [NP-1:0]  has_credit;
    logic [NP-1:0]  send_q;
    flit_t          flit_q     [NP];

    for (genvar p = 0; p < NP; p++) begin : g_port

        flit_fifo u_fifo (
            .clk        (clk),
            .rst        (rst),
            .push       (link_in[p].send),
            .push_flit  (link_in[p].flit),
            .pop        (pop[p]),
            .head       (head[p]),
            .head_valid (head_valid[p]),
            .credit     (credit_out[p])
        );

        assign head_tail[p] = head[p].is_tail;

        // XY order with x first, then y, then eject
        always_comb begin
            if ((int'(head[p].dest) % `NOC_MESH_DIM) != ROUTER_X) begin
                route[p] = port_idx_t'(`NOC_PORT_X);
            end else if ((int'(head[p].dest) / `NOC_MESH_DIM) != ROUTER_Y) begin
                route[p] = port_idx_t'(`NOC_PORT_Y);
            end else begin
                route[p] = port_idx_t'(`NOC_PORT_LOCAL);
            end
        end

        output_allocator u_alloc (
            .clk          (clk),
            .rst          (rst),
            .request      (req[p]),
            .head_is_tail (head_tail),
            .has_credit   (has_credit[p]),
            .grant        (grant[p])
        );

        // Credit is spent at the grant one cycle before send goes out
        credit_counter u_credit (
            .clk           (clk),
            .rst           (rst),
            .sent          (|grant[p]),
            .credit_return (credit_in[p]),
            .has_credit    (has_credit[p])
        );

        assign link_out[p] = '{flit: flit_q[p], send: send_q[p]};

    end

    // Request matrix indexed by output then input
    always_comb begin
        for (int o = 0; o < NP; o++) begin
            for (int i = 0; i < NP; i++) begin
                req[o][i] = head_valid[i] && (route[i] == port_idx_t'(o));
            end
        end
    end

    // An input wins at most one output since it requests only one
    always_comb begin
        pop = '0;
        for (int o = 0; o < NP; o++) begin
            pop = pop | grant[o];
        end
    end

    // Output stage
    always_ff @(posedge clk) begin
        if (rst) begin
            send_q <= '0;
        end else begin
            for (int o = 0; o < NP; o++) begin
                send_q[o] <= |grant[o];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < NP; o++) begin
            for (int i = 0; i < NP; i++) begin
                if (grant[o][i]) begin
                    flit_q[o] <= head[i];
                end
            end
        end
    end

    // Endpoints must not address themselves
    a_no_self_loop: assert property (@(posedge clk) disable iff (rst)
        head_valid[`NOC_PORT_LOCAL] |->
            (route[`NOC_PORT_LOCAL] != port_idx_t'(`NOC_PORT_LOCAL)));

endmodule

`default_nettype wire

/* logic/mesh_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module mesh_top
    import noc_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  link_t local_in   [`NOC_NUM_NODES],
    output logic  credit_out [`NOC_NUM_NODES],

    output link_t local_out  [`NOC_NUM_NODES],
    input  logic  credit_in  [`NOC_NUM_NODES]
);

    localparam int DIM = `NOC_MESH_DIM;

    link_t rtr_in         [`NOC_NUM_NODES][`NOC_NUM_PORTS];
    link_t rtr_out        [`NOC_NUM_NODES][`NOC_NUM_PORTS];
    logic  rtr_credit_in  [`NOC_NUM_NODES][`NOC_NUM_PORTS];
    logic  rtr_credit_out [`NOC_NUM_NODES][`NOC_NUM_PORTS];

    for (genvar n = 0; n < `NOC_NUM_NODES; n++) begin : g_node

        localparam int X = n % DIM;
        localparam int Y = n / DIM;

        // Only neighbour along each axis in a 2x2 mesh
        localparam int XN = Y * DIM + (DIM - 1 - X);
        localparam int YN = (DIM - 1 - Y) * DIM + X;

        noc_router #(
            .ROUTER_X (X),
            .ROUTER_Y (Y)
        ) u_router (
            .clk        (clk),
            .rst        (rst),
            .link_in    (rtr_in[n]),
            .credit_out (rtr_credit_out[n]),
            .link_out   (rtr_out[n]),
            .credit_in  (rtr_credit_in[n])
        );

        // Endpoint side
        assign rtr_in[n][`NOC_PORT_LOCAL]        = local_in[n];
        assign credit_out[n]                     = rtr_credit_out[n][`NOC_PORT_LOCAL];
        assign local_out[n]                      = rtr_out[n][`NOC_PORT_LOCAL];
        assign rtr_credit_in[n][`NOC_PORT_LOCAL] = credit_in[n];

        // Flits cross over, credits come back from the receiving buffer
        assign rtr_in[n][`NOC_PORT_X]        = rtr_out[XN][`NOC_PORT_X];
        assign rtr_credit_in[n][`NOC_PORT_X] = rtr_credit_out[XN][`NOC_PORT_X];

        assign rtr_in[n][`NOC_PORT_Y]        = rtr_out[YN][`NOC_PORT_Y];
        assign rtr_credit_in[n][`NOC_PORT_Y] = rtr_credit_out[YN][`NOC_PORT_Y];

    end

endmodule

`default_nettype wire

/* bench/tb_mesh.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module tb_mesh
    import noc_pkg::*;
();

    localparam int NODES      = `NOC_NUM_NODES;
    localparam int DEPTH      = `NOC_BUF_DEPTH;
    localparam int NUM_PKTS   = 12;
    localparam int MAX_LEN    = 4;
    localparam int HOT_PKTS   = 3;
    localparam int TOTAL_PKTS = NODES * NUM_PKTS;
    localparam int WAIT_LIMIT = 5000;

    logic   clk = 1'b0;
    logic   rst = 1'b1;
    link_t  local_in   [NODES];
    logic   credit_out [NODES];
    link_t  local_out  [NODES];
    logic   credit_in  [NODES];
    integer seed = 32'he24a_9c8c;

    // Expected traffic by source and packet number
    int          pkt_len   [NODES][NUM_PKTS];
    int          pkt_dst   [NODES][NUM_PKTS];
    logic [15:0] flit_tag  [NODES][NUM_PKTS][MAX_LEN];
    logic        delivered [NODES][NUM_PKTS];

    int   gen_credits [NODES];
    int   gen_pkt     [NODES];
    int   gen_flit    [NODES];
    int   pkts_sent;
    logic traffic_started;

    int   sink_pending [NODES];
    int   sink_wait    [NODES];
    logic sink_open    [NODES];
    int   open_src     [NODES];
    int   open_pkt     [NODES];
    int   next_idx     [NODES];
    int   pkts_delivered;

    logic [NODES-1:0] out_send;
    logic [NODES-1:0] credit_seen;

    mesh_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .local_in   (local_in),
        .credit_out (credit_out),
        .local_out  (local_out),
        .credit_in  (credit_in)
    );

    always #5 clk = ~clk;

    task automatic stop_failed();
        $display("Simulation failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        stop_failed();
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
        stop_failed();
    endtask

    function automatic int rand_below(input int limit);
        return int'($unsigned($random(seed)) % limit);
    endfunction

    task automatic build_traffic();
        int dst;
        for (int n = 0; n < NODES; n++) begin
            for (int p = 0; p < NUM_PKTS; p++) begin
                // Early packets converge on one node to load a single output
                if (p < HOT_PKTS) begin
                    dst = (n == NODES - 1) ? 0 : NODES - 1;
                end else begin
                    dst = (n + 1 + rand_below(NODES - 1)) % NODES;
                end
                pkt_dst[n][p]   = dst;
                pkt_len[n][p]   = 1 + rand_below(MAX_LEN);
                delivered[n][p] = 1'b0;
                for (int f = 0; f < MAX_LEN; f++) begin
                    flit_tag[n][p][f] = 16'($random(seed));
                end
            end
        end
    endtask

    // Data holds source, packet number, flit index and a random tag
    function automatic flit_t make_flit(input int src, input int pkt, input int idx);
        flit_t f;
        f.data    = {4'(src), 8'(pkt), 4'(idx), flit_tag[src][pkt][idx]};
        f.dest    = node_id_t'(pkt_dst[src][pkt]);
        f.is_tail = (idx == pkt_len[src][pkt] - 1);
        return f;
    endfunction

    task automatic check_delivery(input int node, input flit_t f);
        int src;
        int pkt;
        int idx;
        src = int'(f.data[31:28]);
        pkt = int'(f.data[27:20]);
        idx = int'(f.data[19:16]);
        a_known_flit: assert (src < NODES && pkt < NUM_PKTS && idx < MAX_LEN)
            else report_error($sformatf("node %0d got unknown data %h", node, f.data));
        a_right_dest: assert (int'(f.dest) == node && pkt_dst[src][pkt] == node)
            else report_error($sformatf("node %0d got a flit of packet %0d.%0d for node %0d",
                node, src, pkt, pkt_dst[src][pkt]));
        a_data_intact: assert (f.data[15:0] == flit_tag[src][pkt][idx])
            else report_error($sformatf("packet %0d.%0d flit %0d tag %h, expected %h",
                src, pkt, idx, f.data[15:0], flit_tag[src][pkt][idx]));
        a_tail_flag: assert (f.is_tail == (idx == pkt_len[src][pkt] - 1))
            else report_error($sformatf("packet %0d.%0d flit %0d has is_tail %0b",
                src, pkt, idx, f.is_tail));
        // A packet owns the sink from its head to its tail
        if (!sink_open[node]) begin
            sink_open[node] = 1'b1;
            open_src[node]  = src;
            open_pkt[node]  = pkt;
            next_idx[node]  = 0;
        end
        a_no_interleave: assert (src == open_src[node] && pkt == open_pkt[node])
            else report_error($sformatf("node %0d got packet %0d.%0d inside packet %0d.%0d",
                node, src, pkt, open_src[node], open_pkt[node]));
        a_in_order: assert (idx == next_idx[node])
            else report_error($sformatf("node %0d got flit %0d, expected flit %0d",
                node, idx, next_idx[node]));
        next_idx[node]++;
        if (f.is_tail) begin
            a_single_delivery: assert (!delivered[src][pkt])
                else report_error($sformatf("packet %0d.%0d delivered twice", src, pkt));
            delivered[src][pkt] = 1'b1;
            pkts_delivered++;
            sink_open[node] = 1'b0;
        end
        sink_pending[node]++;
        a_sink_credit: assert (sink_pending[node] <= DEPTH)
            else report_error($sformatf("node %0d holds %0d flits without credit",
                node, sink_pending[node]));
    endtask

    // Sink returns one credit per flit after 0 to 3 idle cycles
    task automatic serve_sink(input int node);
        if (local_out[node].send) begin
            check_delivery(node, local_out[node].flit);
        end
        credit_in[node] = 1'b0;
        if (sink_pending[node] > 0) begin
            if (sink_wait[node] == 0) begin
                credit_in[node] = 1'b1;
                sink_pending[node]--;
                sink_wait[node] = rand_below(4);
            end else begin
                sink_wait[node]--;
            end
        end
    endtask

    task automatic drive_generator(input int node);
        int p;
        int f;
        if (credit_out[node]) begin
            gen_credits[node]++;
        end
        a_gen_credit: assert (gen_credits[node] <= DEPTH)
            else report_error($sformatf("node %0d got %0d credits back, more than it sent",
                node, gen_credits[node]));
        p = gen_pkt[node];
        f = gen_flit[node];
        local_in[node].send = 1'b0;
        // Random idle cycles vary the contention
        if (p < NUM_PKTS && gen_credits[node] > 0 && rand_below(4) != 0) begin
            local_in[node].flit = make_flit(node, p, f);
            local_in[node].send = 1'b1;
            traffic_started     = 1'b1;
            gen_credits[node]--;
            if (f == pkt_len[node][p] - 1) begin
                gen_pkt[node]++;
                gen_flit[node] = 0;
                pkts_sent++;
            end else begin
                gen_flit[node]++;
            end
        end
    endtask

    function automatic logic credits_home();
        for (int n = 0; n < NODES; n++) begin
            if (gen_credits[n] != DEPTH || sink_pending[n] != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    always_comb begin
        for (int n = 0; n < NODES; n++) begin
            out_send[n]    = local_out[n].send;
            credit_seen[n] = credit_out[n];
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !traffic_started |-> (out_send == '0 && credit_seen == '0))
        else report_error("send or credit left the mesh before any flit went in");

    // Sinks run before generators on every falling edge
    initial begin
        traffic_started = 1'b0;
        pkts_sent       = 0;
        pkts_delivered  = 0;
        for (int n = 0; n < NODES; n++) begin
            local_in[n]     = '0;
            credit_in[n]    = 1'b0;
            gen_credits[n]  = DEPTH;
            gen_pkt[n]      = 0;
            gen_flit[n]     = 0;
            sink_pending[n] = 0;
            sink_wait[n]    = 0;
            sink_open[n]    = 1'b0;
            open_src[n]     = 0;
            open_pkt[n]     = 0;
            next_idx[n]     = 0;
        end
        build_traffic();
        forever begin
            @(negedge clk);
            if (!rst) begin
                for (int n = 0; n < NODES; n++) begin
                    serve_sink(n);
                    drive_generator(n);
                end
            end
        end
    end

    initial begin
        int waited;
        repeat (2) @(negedge clk);
        rst <= 1'b0;

        waited = 0;
        while (pkts_sent < TOTAL_PKTS) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("every generator to send all of its packets");
            end
        end

        waited = 0;
        while (pkts_delivered < TOTAL_PKTS) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("every packet to reach its destination");
            end
        end

        waited = 0;
        while (!credits_home()) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("all credits to return to the generators");
            end
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
logic/noc_pkg.sv
logic/flit_fifo.sv
logic/credit_counter.sv
logic/output_allocator.sv
logic/noc_router.sv
logic/mesh_top.sv
bench/tb_mesh.sv

/* run.sh */
#!/bin/sh
# Build and run the mesh testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_mesh -f flist.f -o tb_mesh_sim

./obj_dir/tb_mesh_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Simulation completed successfully" sim.log
